/* stick_cfg_pkg.sv */
`default_nettype none

package stick_cfg_pkg;

	// --------------------------------------------------
	// widths with a meaning
	// --------------------------------------------------
	typedef logic [11:0] sample_t;	// raw adc sample
	typedef logic [23:0] delay_t;	// delay in sysclk cycles
	typedef logic [7:0]  byte_t;	// width, group size, word count, offset

	// hv code, all ones is full voltage, zero is off
	typedef logic [2:0]  hv_t;

	// settings of one physical channel
	typedef struct packed {
		delay_t znd_delay;		// sync to probe pulse
		byte_t  pulse_w;		// probe pulse width
		delay_t data_delay;		// sync to first sample
		byte_t  smax_num;		// samples per group
		byte_t  words_num;		// groups per cycle
		byte_t  offset;			// subtracted from group max
	} ch_cfg_t;

	// one output word of a channel
	typedef struct packed {
		byte_t   cnt;			// word number, 0 first
		sample_t value;			// max minus offset, floor 0
	} acq_word_t;

	// --------------------------------------------------
	// state machines
	// --------------------------------------------------
	typedef enum logic [1:0] {
		ZND_IDLE,
		ZND_WAIT,				// counting znd_delay
		ZND_PULSE				// phases active
	} znd_state_t;

	typedef enum logic [1:0] {
		ACQ_IDLE,
		ACQ_WAIT,				// counting data_delay, doffs high
		ACQ_GROUP				// sampling groups
	} acq_state_t;

endpackage

`default_nettype wire

/* stick_cmd_pkg.sv */
`default_nettype none

package stick_cmd_pkg;

	// --------------------------------------------------
	// opcodes of the 32-bit command word
	// --------------------------------------------------
	typedef enum logic [4:0] {
		OP_ZND_DELAY  = 5'd1,	// per channel, 24 bit arg
		OP_PULSE_W    = 5'd2,	// per channel, low byte
		OP_DATA_DELAY = 5'd3,	// per channel, 24 bit arg
		OP_SMAX       = 5'd4,	// per channel, low byte
		OP_WORDS      = 5'd5,	// per channel, low byte
		OP_OFFSET     = 5'd6,	// per channel, low byte
		OP_POWER      = 5'd7,	// board, pdwn mask and hv code
		OP_SYNC       = 5'd16	// board, internal sync enable
	} cmd_op_t;

	// lsb of the hv code in an OP_POWER arg, the pdwn mask sits below it
	localparam int PWR_HV_LSB = 4;

	// command word, set flag on top
	typedef struct packed {
		logic        set;		// bit 31, clear means ignore
		logic [4:0]  op;		// raw, unknown codes possible
		logic [1:0]  ch;		// physical channel
		logic [23:0] arg;
	} cmd_t;

endpackage

`default_nettype wire

/* cmd_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_regs #(
	parameter int NUM_CH = 4
) (
	input  wire logic                                 i_sysclk,
	input  wire logic                                 i_phy_rst_n,
	input  wire logic                                 i_cmd_valid,	// one cycle strobe
	input  wire stick_cmd_pkg::cmd_t                  i_cmd,
	output logic                                      o_sync_on,
	output stick_cfg_pkg::ch_cfg_t [NUM_CH-1:0]       o_cfg,
	output logic [NUM_CH-1:0]                         o_pdwn,
	output stick_cfg_pkg::hv_t                        o_hv
);

	stick_cmd_pkg::cmd_op_t op;		// opcode seen as enum
	logic                   cmd_set;	// accepted command this cycle

	assign op      = stick_cmd_pkg::cmd_op_t'(i_cmd.op);
	assign cmd_set = i_cmd_valid && i_cmd.set;

	// --------------------------------------------------
	// board registers
	// --------------------------------------------------
	always_ff @(posedge i_sysclk or negedge i_phy_rst_n)
	begin
		if (!i_phy_rst_n)
		begin
			o_pdwn    <= '0;	// all channels powered
			o_hv      <= '0;	// hv off
			o_sync_on <= 1'b0;
		end
		else if (cmd_set)
		begin
			case (op)
				stick_cmd_pkg::OP_POWER:
				begin
					o_pdwn <= i_cmd.arg[NUM_CH-1:0];
					o_hv   <= i_cmd.arg[stick_cmd_pkg::PWR_HV_LSB +: 3];
				end
				stick_cmd_pkg::OP_SYNC:
					o_sync_on <= i_cmd.arg[0];
				default: ;	// channel ops handled below
			endcase
		end
	end

	// --------------------------------------------------
	// per channel settings
	// --------------------------------------------------
	always_ff @(posedge i_sysclk or negedge i_phy_rst_n)
	begin
		if (!i_phy_rst_n)
			o_cfg <= '0;
		else if (cmd_set)
		begin
			for (int i = 0; i < NUM_CH; i++)
			begin
				if (i_cmd.ch == 2'(i))	// addressed channel only
				begin
					case (op)
						stick_cmd_pkg::OP_ZND_DELAY:  o_cfg[i].znd_delay  <= i_cmd.arg;
						stick_cmd_pkg::OP_PULSE_W:    o_cfg[i].pulse_w    <= i_cmd.arg[7:0];
						stick_cmd_pkg::OP_DATA_DELAY: o_cfg[i].data_delay <= i_cmd.arg;
						stick_cmd_pkg::OP_SMAX:       o_cfg[i].smax_num   <= i_cmd.arg[7:0];
						stick_cmd_pkg::OP_WORDS:      o_cfg[i].words_num  <= i_cmd.arg[7:0];
						stick_cmd_pkg::OP_OFFSET:     o_cfg[i].offset     <= i_cmd.arg[7:0];
						default: ;	// board op or unknown
					endcase
				end
			end
		end
	end

	// host must only address channels that exist on this build
	a_ch_range: assert property (@(posedge i_sysclk) disable iff (!i_phy_rst_n)
		cmd_set |-> (int'(i_cmd.ch) < NUM_CH));

endmodule

`default_nettype wire

/* sync_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_gen #(
	parameter int SYNC_BIT = 20	// period is 2**(SYNC_BIT+1) cycles
) (
	input  wire logic i_sysclk,
	input  wire logic i_phy_rst_n,
	input  wire logic i_sync_on,
	output logic      o_msync_n,	// master sync level
	output logic      o_sync_stb	// one cycle after the fall
);

	logic [SYNC_BIT:0] cnt_q;		// free running
	logic              msync_d;		// last cycle level

	// low half of the counter period is the sync
	assign o_msync_n = i_sync_on ? cnt_q[SYNC_BIT] : 1'b1;

	// --------------------------------------------------
	// counter and fall detect
	// --------------------------------------------------
	always_ff @(posedge i_sysclk or negedge i_phy_rst_n)
	begin
		if (!i_phy_rst_n)
		begin
			cnt_q      <= '0;
			msync_d    <= 1'b1;
			o_sync_stb <= 1'b0;
		end
		else
		begin
			cnt_q      <= cnt_q + 1'b1;
			msync_d    <= o_msync_n;
			o_sync_stb <= msync_d & ~o_msync_n;	// high to low seen
		end
	end

	// channels restart on every strobe, a double one would skew them
	a_stb_single: assert property (@(posedge i_sysclk) disable iff (!i_phy_rst_n)
		o_sync_stb |=> !o_sync_stb);

endmodule

`default_nettype wire

/* znd_chan.sv */
`timescale 1ns/1ps
`default_nettype none

module znd_chan (
	input  wire logic                    i_sysclk,
	input  wire logic                    i_phy_rst_n,
	input  wire logic                    i_sync_stb,
	input  wire stick_cfg_pkg::ch_cfg_t  i_cfg,
	input  wire logic                    i_pdwn,	// channel asleep
	output logic                         o_imp_a,
	output logic                         o_imp_b_n,
	output logic                         o_imp_c,
	output logic                         o_imp_d_n,
	output logic                         o_enz_n
);

	stick_cfg_pkg::znd_state_t state_q;
	stick_cfg_pkg::delay_t     dly_q;	// remaining wait cycles
	stick_cfg_pkg::byte_t      wid_q;	// remaining pulse cycles

	// --------------------------------------------------
	// sequencer, strobe cycle counts as 0
	// --------------------------------------------------
	always_ff @(posedge i_sysclk or negedge i_phy_rst_n)
	begin
		if (!i_phy_rst_n)
		begin
			state_q   <= stick_cfg_pkg::ZND_IDLE;
			dly_q     <= '0;
			wid_q     <= '0;
			o_imp_a   <= 1'b0;
			o_imp_b_n <= 1'b1;
		end
		else if (i_pdwn || (i_sync_stb && i_cfg.pulse_w == '0))
		begin
			state_q   <= stick_cfg_pkg::ZND_IDLE;	// no pulse at all
			o_imp_a   <= 1'b0;
			o_imp_b_n <= 1'b1;
		end
		else if (i_sync_stb)	// restart even mid pulse
		begin
			wid_q     <= i_cfg.pulse_w - 8'd1;
			dly_q     <= i_cfg.znd_delay - 24'd1;
			o_imp_a   <= (i_cfg.znd_delay == '0);
			o_imp_b_n <= (i_cfg.znd_delay != '0);
			state_q   <= (i_cfg.znd_delay == '0) ? stick_cfg_pkg::ZND_PULSE
			                                      : stick_cfg_pkg::ZND_WAIT;
		end
		else
		begin
			case (state_q)
				stick_cfg_pkg::ZND_WAIT:
					if (dly_q == '0)
					begin
						state_q   <= stick_cfg_pkg::ZND_PULSE;	// rises at znd_delay+1
						o_imp_a   <= 1'b1;
						o_imp_b_n <= 1'b0;
					end
					else
						dly_q <= dly_q - 24'd1;
				stick_cfg_pkg::ZND_PULSE:
					if (wid_q == '0)
					begin
						state_q   <= stick_cfg_pkg::ZND_IDLE;	// pulse_w cycles done
						o_imp_a   <= 1'b0;
						o_imp_b_n <= 1'b1;
					end
					else
						wid_q <= wid_q - 8'd1;
				default: ;
			endcase
		end
	end

	assign o_imp_c   = o_imp_a;		// c follows a
	assign o_imp_d_n = o_imp_b_n;
	assign o_enz_n   = o_imp_b_n;	// driver enabled while pulsing

	// both bridge halves on at once would short the probe driver
	a_phase_compl: assert property (@(posedge i_sysclk) disable iff (!i_phy_rst_n)
		o_imp_a != o_imp_b_n);

endmodule

`default_nettype wire

/* acq_chan.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_chan (
	input  wire logic                      i_sysclk,
	input  wire logic                      i_phy_rst_n,
	input  wire logic                      i_sync_stb,
	input  wire stick_cfg_pkg::ch_cfg_t    i_cfg,
	input  wire logic                      i_pdwn,
	input  wire stick_cfg_pkg::sample_t    i_adc,
	output logic                           o_valid,	// one cycle per word
	output stick_cfg_pkg::acq_word_t       o_word,
	output logic                           o_cmpl,	// with the last word
	output logic                           o_en,
	output logic                           o_doffs,
	output logic                           o_soffs_n
);

	stick_cfg_pkg::acq_state_t state_q;
	stick_cfg_pkg::delay_t     dly_q;		// remaining wait cycles
	stick_cfg_pkg::byte_t      pos_q;		// sample index in group
	stick_cfg_pkg::byte_t      wcnt_q;		// word number in cycle
	stick_cfg_pkg::sample_t    max_q;		// running max
	stick_cfg_pkg::sample_t    grp_max;		// max including this sample
	stick_cfg_pkg::sample_t    offs;		// offset, zero extended
	logic                      run_ok;		// settings allow a cycle
	logic                      last_smp;	// group closes this cycle
	logic                      last_word;

	assign run_ok    = !i_pdwn && (i_cfg.smax_num != '0) && (i_cfg.words_num != '0);
	assign grp_max   = (pos_q == '0 || i_adc > max_q) ? i_adc : max_q;	// first sample seeds
	assign offs      = stick_cfg_pkg::sample_t'(i_cfg.offset);
	assign last_smp  = (pos_q == i_cfg.smax_num - 8'd1);
	assign last_word = (wcnt_q == i_cfg.words_num - 8'd1);

	// --------------------------------------------------
	// control, strobe cycle counts as 0
	// --------------------------------------------------
	always_ff @(posedge i_sysclk or negedge i_phy_rst_n)
	begin
		if (!i_phy_rst_n)
		begin
			state_q <= stick_cfg_pkg::ACQ_IDLE;
			dly_q   <= '0;
			pos_q   <= '0;
			wcnt_q  <= '0;
			o_valid <= 1'b0;
			o_cmpl  <= 1'b0;
		end
		else
		begin
			o_valid <= 1'b0;	// strobes by default
			o_cmpl  <= 1'b0;
			if (!run_ok)
				state_q <= stick_cfg_pkg::ACQ_IDLE;
			else if (i_sync_stb)
			begin
				pos_q   <= '0;
				wcnt_q  <= '0;
				dly_q   <= i_cfg.data_delay - 24'd1;
				state_q <= (i_cfg.data_delay == '0) ? stick_cfg_pkg::ACQ_GROUP
				                                     : stick_cfg_pkg::ACQ_WAIT;
			end
			else
			begin
				case (state_q)
					stick_cfg_pkg::ACQ_WAIT:
						if (dly_q == '0)
							state_q <= stick_cfg_pkg::ACQ_GROUP;	// first sample at data_delay+1
						else
							dly_q <= dly_q - 24'd1;
					stick_cfg_pkg::ACQ_GROUP:
						if (last_smp)
						begin
							o_valid <= 1'b1;
							pos_q   <= '0;		// next group back to back
							if (last_word)
							begin
								o_cmpl  <= 1'b1;
								state_q <= stick_cfg_pkg::ACQ_IDLE;
							end
							else
								wcnt_q <= wcnt_q + 8'd1;
						end
						else
							pos_q <= pos_q + 8'd1;
					default: ;
				endcase
			end
		end
	end

	// --------------------------------------------------
	// datapath, qualified by o_valid
	// --------------------------------------------------
	always_ff @(posedge i_sysclk)
	begin
		if (state_q == stick_cfg_pkg::ACQ_GROUP)
		begin
			max_q <= grp_max;
			if (last_smp)
			begin
				o_word.cnt   <= wcnt_q;
				o_word.value <= (grp_max > offs) ? grp_max - offs : '0;	// floor at 0
			end
		end
	end

	assign o_en      = (state_q == stick_cfg_pkg::ACQ_GROUP);
	assign o_doffs   = (state_q == stick_cfg_pkg::ACQ_WAIT);	// offset calibration window
	assign o_soffs_n = ~o_doffs;

	// completion must close out exactly words_num words
	a_cmpl_last: assert property (@(posedge i_sysclk) disable iff (!i_phy_rst_n)
		o_cmpl |-> o_valid && (o_word.cnt == i_cfg.words_num - 8'd1));

endmodule

`default_nettype wire

/* stick_top.sv */
`timescale 1ns/1ps
`default_nettype none

module stick_top #(
	parameter int NUM_CH   = 4,
	parameter int SYNC_BIT = 20
) (
	input  wire logic                                   i_sysclk,
	input  wire logic                                   i_phy_rst_n,
	// command strobe
	input  wire logic                                   i_cmd_valid,
	input  wire stick_cmd_pkg::cmd_t                    i_cmd,
	// adc streams
	input  wire stick_cfg_pkg::sample_t [NUM_CH-1:0]    i_adc,
	// board level
	output wire logic                                   o_msync_n,
	output wire stick_cfg_pkg::hv_t                     o_hpwon,
	output wire logic [NUM_CH-1:0]                      o_pdwn,
	// probe pulse
	output wire logic [NUM_CH-1:0]                      o_phase_a,
	output wire logic [NUM_CH-1:0]                      o_phase_b_n,
	output wire logic [NUM_CH-1:0]                      o_phase_c,
	output wire logic [NUM_CH-1:0]                      o_phase_d_n,
	output wire logic [NUM_CH-1:0]                      o_nenz,
	// acquisition
	output wire logic [NUM_CH-1:0]                      o_acq_valid,
	output wire logic [NUM_CH-1:0]                      o_acq_cmpl,
	output wire logic [NUM_CH-1:0]                      o_en,
	output wire logic [NUM_CH-1:0]                      o_doffs,
	output wire logic [NUM_CH-1:0]                      o_soffs_n,
	output wire stick_cfg_pkg::acq_word_t [NUM_CH-1:0]  o_acq_word
);

	stick_cfg_pkg::ch_cfg_t [NUM_CH-1:0] cfg;	// per channel settings
	logic                                sync_on;
	logic                                sync_stb;	// shared by all channels

	// --------------------------------------------------
	// settings and sync
	// --------------------------------------------------
	cmd_regs #(
		.NUM_CH(NUM_CH)
	) u_cmd_regs (
		.i_sysclk    (i_sysclk),
		.i_phy_rst_n (i_phy_rst_n),
		.i_cmd_valid (i_cmd_valid),
		.i_cmd       (i_cmd),
		.o_sync_on   (sync_on),
		.o_cfg       (cfg),
		.o_pdwn      (o_pdwn),
		.o_hv        (o_hpwon)
	);

	sync_gen #(
		.SYNC_BIT(SYNC_BIT)
	) u_sync_gen (
		.i_sysclk    (i_sysclk),
		.i_phy_rst_n (i_phy_rst_n),
		.i_sync_on   (sync_on),
		.o_msync_n   (o_msync_n),
		.o_sync_stb  (sync_stb)
	);

	// --------------------------------------------------
	// one probe sequencer and one acquirer per channel
	// --------------------------------------------------
	for (genvar g = 0; g < NUM_CH; g++)
	begin : g_ch
		znd_chan u_znd (
			.i_sysclk    (i_sysclk),
			.i_phy_rst_n (i_phy_rst_n),
			.i_sync_stb  (sync_stb),
			.i_cfg       (cfg[g]),
			.i_pdwn      (o_pdwn[g]),
			.o_imp_a     (o_phase_a[g]),
			.o_imp_b_n   (o_phase_b_n[g]),
			.o_imp_c     (o_phase_c[g]),
			.o_imp_d_n   (o_phase_d_n[g]),
			.o_enz_n     (o_nenz[g])
		);

		acq_chan u_acq (
			.i_sysclk    (i_sysclk),
			.i_phy_rst_n (i_phy_rst_n),
			.i_sync_stb  (sync_stb),
			.i_cfg       (cfg[g]),
			.i_pdwn      (o_pdwn[g]),
			.i_adc       (i_adc[g]),
			.o_valid     (o_acq_valid[g]),
			.o_word      (o_acq_word[g]),
			.o_cmpl      (o_acq_cmpl[g]),
			.o_en        (o_en[g]),
			.o_doffs     (o_doffs[g]),
			.o_soffs_n   (o_soffs_n[g])
		);
	end

endmodule

`default_nettype wire

/* tb_stick.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_stick;

	localparam int NUM_CH   = 4;
	localparam int SYNC_BIT = 9;
	localparam int PERIOD   = 1024;	// sync period for SYNC_BIT 9
	localparam int NUM_ROWS = 3;
	localparam logic [31:0] LCG_SEED = 32'ha312_31c7;

	// one scenario of the table
	typedef struct packed {
		stick_cfg_pkg::ch_cfg_t [NUM_CH-1:0] cfg;
		logic [NUM_CH-1:0]                   pdwn;
		stick_cfg_pkg::hv_t                  hv;
		stick_cfg_pkg::sample_t              adc_mask;	// keeps samples small
		logic [31:0]                         seed;		// xor with base seed
	} row_t;

	logic                                   sysclk;
	logic                                   phy_rst_n;
	logic                                   cmd_valid;
	stick_cmd_pkg::cmd_t                    cmd;
	stick_cfg_pkg::sample_t [NUM_CH-1:0]    adc;
	wire                                    msync_n;
	wire stick_cfg_pkg::hv_t                hpwon;
	wire [NUM_CH-1:0]                       pdwn;
	wire [NUM_CH-1:0]                       phase_a, phase_b_n, phase_c, phase_d_n, nenz;
	wire [NUM_CH-1:0]                       acq_valid, acq_cmpl, en, doffs, soffs_n;
	wire stick_cfg_pkg::acq_word_t [NUM_CH-1:0] acq_word;

	row_t                   rows [NUM_ROWS];
	stick_cfg_pkg::sample_t adc_tab [NUM_CH][PERIOD];	// samples per window after the fall
	logic [31:0]            rng;
	int                     errors;
	int                     checks;

	stick_top #(
		.NUM_CH   (NUM_CH),
		.SYNC_BIT (SYNC_BIT)
	) i_stick_top (
		.i_sysclk    (sysclk),
		.i_phy_rst_n (phy_rst_n),
		.i_cmd_valid (cmd_valid),
		.i_cmd       (cmd),
		.i_adc       (adc),
		.o_msync_n   (msync_n),
		.o_hpwon     (hpwon),
		.o_pdwn      (pdwn),
		.o_phase_a   (phase_a),
		.o_phase_b_n (phase_b_n),
		.o_phase_c   (phase_c),
		.o_phase_d_n (phase_d_n),
		.o_nenz      (nenz),
		.o_acq_valid (acq_valid),
		.o_acq_cmpl  (acq_cmpl),
		.o_en        (en),
		.o_doffs     (doffs),
		.o_soffs_n   (soffs_n),
		.o_acq_word  (acq_word)
	);

	initial
	begin
		sysclk = 1'b0;
		forever #5 sysclk = ~sysclk;	// 100 MHz
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic stick_cfg_pkg::ch_cfg_t make_cfg(input int zd, input int pw,
		input int dd, input int s, input int w, input int off);
		stick_cfg_pkg::ch_cfg_t c;
		c.znd_delay  = 24'(zd);
		c.pulse_w    = 8'(pw);
		c.data_delay = 24'(dd);
		c.smax_num   = 8'(s);
		c.words_num  = 8'(w);
		c.offset     = 8'(off);
		return c;
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("ERR t=%0t %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	task automatic send_cmd(input stick_cmd_pkg::cmd_op_t op, input int ch,
		input logic [23:0] arg);
		@(posedge sysclk);
		#1;
		cmd_valid = 1'b1;
		cmd       = {1'b1, op, 2'(ch), arg};
		@(posedge sysclk);
		#1;
		cmd_valid = 1'b0;	// one cycle strobe
	endtask

	// next high to low of msync_n, sampled mid cycle
	task automatic wait_fall(output int cycles);
		logic prev;
		int   n;
		prev   = msync_n;
		cycles = 0;
		for (n = 0; n < 2*PERIOD + 16; n++)
		begin
			@(posedge sysclk);
			#4;
			cycles = n + 1;	// edges since the call
			if (prev && !msync_n)
				return;
			prev = msync_n;
		end
		errors++;
		$display("timeout: msync_n did not fall within %0d cycles", 2*PERIOD + 16);
	endtask

	task automatic check_idle();
		check("o_msync_n", 32'd1, 32'(msync_n));
		check("o_phase_a", 32'd0, 32'(phase_a));
		check("o_phase_b_n", 32'hf, 32'(phase_b_n));
		check("o_phase_c", 32'd0, 32'(phase_c));
		check("o_phase_d_n", 32'hf, 32'(phase_d_n));
		check("o_nenz", 32'hf, 32'(nenz));
		check("o_acq_valid", 32'd0, 32'(acq_valid));
		check("o_acq_cmpl", 32'd0, 32'(acq_cmpl));
		check("o_en", 32'd0, 32'(en));
		check("o_doffs", 32'd0, 32'(doffs));
		check("o_soffs_n", 32'hf, 32'(soffs_n));
	endtask

	// reference model, window k is the k-th cycle after the msync_n fall
	task automatic check_window(input int r, input int k);
		int    zd, pw, dd, s, w, off, j, mx;
		logic  pulse, act, vld, en_e, doffs_e;
		string sfx;
		check("o_msync_n", 32'(k >= PERIOD/2), 32'(msync_n));	// low half first
		for (int c = 0; c < NUM_CH; c++)
		begin
			zd  = int'(rows[r].cfg[c].znd_delay);
			pw  = int'(rows[r].cfg[c].pulse_w);
			dd  = int'(rows[r].cfg[c].data_delay);
			s   = int'(rows[r].cfg[c].smax_num);
			w   = int'(rows[r].cfg[c].words_num);
			off = int'(rows[r].cfg[c].offset);
			sfx = $sformatf("[%0d]", c);
			pulse   = !rows[r].pdwn[c] && pw > 0 && k >= zd + 2 && k < zd + 2 + pw;
			act     = !rows[r].pdwn[c] && s > 0 && w > 0;
			en_e    = act && k >= dd + 2 && k < dd + 2 + w*s;	// sample windows
			doffs_e = act && k >= 2 && k < dd + 2;
			vld     = 1'b0;
			j       = 0;
			if (act && k > dd + 2 && (k - dd - 2) % s == 0)
			begin
				j   = (k - dd - 2) / s - 1;	// group that just closed
				vld = (j < w);
			end
			check({"o_phase_a", sfx}, 32'(pulse), 32'(phase_a[c]));
			check({"o_phase_b_n", sfx}, 32'(!pulse), 32'(phase_b_n[c]));
			check({"o_phase_c", sfx}, 32'(pulse), 32'(phase_c[c]));
			check({"o_phase_d_n", sfx}, 32'(!pulse), 32'(phase_d_n[c]));
			check({"o_nenz", sfx}, 32'(!pulse), 32'(nenz[c]));
			check({"o_en", sfx}, 32'(en_e), 32'(en[c]));
			check({"o_doffs", sfx}, 32'(doffs_e), 32'(doffs[c]));
			check({"o_soffs_n", sfx}, 32'(!doffs_e), 32'(soffs_n[c]));
			check({"o_acq_valid", sfx}, 32'(vld), 32'(acq_valid[c]));
			check({"o_acq_cmpl", sfx}, 32'(vld && j == w - 1), 32'(acq_cmpl[c]));
			if (vld)
			begin
				mx = 0;
				for (int p = 0; p < s; p++)
					if (int'(adc_tab[c][dd + 2 + j*s + p]) > mx)
						mx = int'(adc_tab[c][dd + 2 + j*s + p]);
				check({"o_acq_word.cnt", sfx}, 32'(j), 32'(acq_word[c].cnt));
				check({"o_acq_word.value", sfx}, 32'(mx > off ? mx - off : 0),
					32'(acq_word[c].value));
			end
		end
	endtask

	// --------------------------------------------------
	// scenario table
	// --------------------------------------------------
	task automatic fill_rows();
		// all channels on, mixed sizes, big offset on ch2
		rows[0].cfg[0]   = make_cfg(10, 5, 20, 4, 8, 0);
		rows[0].cfg[1]   = make_cfg(0, 1, 0, 1, 16, 30);
		rows[0].cfg[2]   = make_cfg(100, 40, 50, 7, 10, 255);
		rows[0].cfg[3]   = make_cfg(3, 255, 200, 16, 12, 8);
		rows[0].pdwn     = 4'b0000;
		rows[0].hv       = 3'd5;
		rows[0].adc_mask = 12'hfff;
		rows[0].seed     = 32'd0;
		// small samples, offsets above them, zero width and zero group size
		rows[1].cfg[0]   = make_cfg(5, 2, 5, 3, 20, 200);
		rows[1].cfg[1]   = make_cfg(7, 3, 9, 2, 5, 64);
		rows[1].cfg[2]   = make_cfg(1, 0, 1, 5, 6, 127);
		rows[1].cfg[3]   = make_cfg(2, 9, 12, 0, 4, 0);
		rows[1].pdwn     = 4'b0000;
		rows[1].hv       = 3'd7;
		rows[1].adc_mask = 12'h07f;
		rows[1].seed     = 32'd1;
		// ch0 and ch2 powered down
		rows[2].cfg[0]   = make_cfg(4, 4, 4, 4, 4, 4);
		rows[2].cfg[1]   = make_cfg(20, 6, 30, 6, 7, 16);
		rows[2].cfg[2]   = make_cfg(4, 4, 4, 4, 4, 4);
		rows[2].cfg[3]   = make_cfg(250, 100, 300, 3, 50, 1);
		rows[2].pdwn     = 4'b0101;
		rows[2].hv       = 3'd2;
		rows[2].adc_mask = 12'hfff;
		rows[2].seed     = 32'd2;
	endtask

	task automatic run_row(input int r);
		int per;	// cycles between two falls
		rng = LCG_SEED ^ rows[r].seed;
		for (int k = 0; k < PERIOD; k++)
			for (int c = 0; c < NUM_CH; c++)
			begin
				rng = lcg(rng);
				adc_tab[c][k] = rng[27:16] & rows[r].adc_mask;
			end
		send_cmd(stick_cmd_pkg::OP_POWER, 0, {17'd0, rows[r].hv, rows[r].pdwn});
		for (int c = 0; c < NUM_CH; c++)
		begin
			send_cmd(stick_cmd_pkg::OP_ZND_DELAY, c, rows[r].cfg[c].znd_delay);
			send_cmd(stick_cmd_pkg::OP_PULSE_W, c, {16'd0, rows[r].cfg[c].pulse_w});
			send_cmd(stick_cmd_pkg::OP_DATA_DELAY, c, rows[r].cfg[c].data_delay);
			send_cmd(stick_cmd_pkg::OP_SMAX, c, {16'd0, rows[r].cfg[c].smax_num});
			send_cmd(stick_cmd_pkg::OP_WORDS, c, {16'd0, rows[r].cfg[c].words_num});
			send_cmd(stick_cmd_pkg::OP_OFFSET, c, {16'd0, rows[r].cfg[c].offset});
		end
		send_cmd(stick_cmd_pkg::OP_SYNC, 0, 24'd1);
		check("o_pdwn", 32'(rows[r].pdwn), 32'(pdwn));
		check("o_hpwon", 32'(rows[r].hv), 32'(hpwon));
		wait_fall(per);	// first fall may cut a period short
		wait_fall(per);
		check("o_msync_n period", PERIOD, per);
		check_window(r, 0);
		for (int k = 1; k < PERIOD; k++)
		begin
			@(posedge sysclk);
			#1;
			for (int c = 0; c < NUM_CH; c++)
				adc[c] = adc_tab[c][k];
			#3;
			check_window(r, k);
		end
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial
	begin
		errors    = 0;
		checks    = 0;
		phy_rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd       = '0;
		adc       = '0;
		fill_rows();
		repeat (5) @(posedge sysclk);
		#1;
		phy_rst_n = 1'b1;
		for (int i = 0; i < 3000; i++)	// quiet after reset, sync off
		begin
			@(posedge sysclk);
			#4;
			check_idle();
			check("o_hpwon", 32'd0, 32'(hpwon));
			check("o_pdwn", 32'd0, 32'(pdwn));
		end
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		send_cmd(stick_cmd_pkg::OP_SYNC, 0, 24'd0);
		for (int i = 0; i < 600; i++)	// last cycle drains
		begin
			@(posedge sysclk);
			#4;
			check("o_msync_n", 32'd1, 32'(msync_n));
		end
		for (int i = 0; i < 3000; i++)
		begin
			@(posedge sysclk);
			#4;
			check_idle();
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
stick_cfg_pkg.sv
stick_cmd_pkg.sv
cmd_regs.sv
sync_gen.sv
znd_chan.sv
acq_chan.sv
stick_top.sv
tb_stick.sv

/* Makefile */
SRCS := $(shell cat filelist.f)

obj_dir/Vtb_stick: filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_stick -f filelist.f

run: obj_dir/Vtb_stick
	./obj_dir/Vtb_stick | tee /dev/stderr | grep -qF "Simulation finished: PASS"

clean:
	rm -rf obj_dir

.PHONY: run clean
